/* tests/psg_test_soc_golden.txt */
# op adr data sel exp_data exp_err, all hex; W ignores exp_data
# W write, R read, T poll until exp_data, S sound magnitude, O o_gpio, G random gpio read
W 00000010 11223344 f 00000000 0
R 00000010 00000000 f 11223344 0
W 00000010 aabbccdd 5 00000000 0
R 00000010 00000000 f 11bb33dd 0
W 000003fc 5a5a5a5a f 00000000 0
W 000003fc 0000a500 2 00000000 0
R 000003fc 00000000 f 5a5aa55a 0
W 10000000 000000c3 1 00000000 0
O 00000000 00000000 0 000000c3 0
R 10000000 00000000 f 000000c3 0
G 10000004 00000000 f 00000000 0
W 10020000 00000028 f 00000000 0
T 10020004 00000000 f 00000001 0
R 10020000 00000000 f 00000000 0
W 10020000 00000028 f 00000000 0
R 10020004 00000000 f 00000000 0
R 20000000 00000000 f 00000000 1
W 20000000 12345678 f 00000000 1
R 00000010 00000000 f 11bb33dd 0
W 10001000 00050004 f 00000000 0
W 10001004 000a0123 f 00000000 0
R 10001000 00000000 f 00050004 0
R 10001004 00000000 f 000a0123 0
W 1000100c 00000001 f 00000000 0
R 1000100c 00000000 f 00000001 0
S 00000000 00000000 0 00000a00 0
W 1000100c 00000000 f 00000000 0
S 00000000 00000000 0 00000000 0

/* vlog.f */
common/soc_pkg.sv
hw/wb_host_bridge.sv
hw/wb_interconnect_sharedbus.sv
hw/wb_spram.sv
hw/wb_gpio.sv
hw/wb_timer.sv
psg/psg_channel.sv
psg/psg_wb.sv
hw/psg_test_soc.sv
tests/tb_psg_test_soc.sv

/* Bender.yml */
package:
  name: psg_test_soc

sources:
  - files:
      - common/soc_pkg.sv
      - hw/wb_host_bridge.sv
      - hw/wb_interconnect_sharedbus.sv
      - hw/wb_spram.sv
      - hw/wb_gpio.sv
      - hw/wb_timer.sv
      - psg/psg_channel.sv
      - psg/psg_wb.sv
      - hw/psg_test_soc.sv
  - target: test
    files:
      - tests/tb_psg_test_soc.sv

/* tests/tb_psg_test_soc.sv */
`timescale 1ns/100ps

module tb_psg_test_soc
  import soc_pkg::*;
();

  localparam int CMD_TIMEOUT = 50;
  localparam int RSP_LAT     = 3;    // Acceptance edge to response pulse
  localparam int POLL_MAX    = 100;
  localparam int SND_TIMEOUT = 2000;
  localparam int GPIO_SETTLE = 3;

  logic                        i_sys_clk;
  logic                        i_rst_n;
  logic                        i_cmd_valid;
  logic                        i_cmd_we;
  logic [WB_AW-1:0]            i_cmd_adr;
  logic [WB_DW-1:0]            i_cmd_dat;
  logic [WB_SW-1:0]            i_cmd_sel;
  logic                        o_cmd_ready;
  logic                        o_rsp_valid;
  logic [WB_DW-1:0]            o_rsp_dat;
  logic                        o_rsp_err;
  logic [GPIO_W-1:0]           i_gpio;
  logic [GPIO_W-1:0]           o_gpio;
  logic signed [PSG_SND_W-1:0] o_sound;

  logic [31:0] lfsr_q;
  int          err_cnt;
  int          step_cnt;
  logic        aborted;

  psg_test_soc i_psg_test_soc (.*);

  initial begin
    i_sys_clk = 1'b0;
    forever #5 i_sys_clk = ~i_sys_clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};  // One step per bit
    end
    take_bits = v;
  endfunction

  task automatic note_timeout(input string what);
    $display("timeout while waiting for %s", what);
    err_cnt++;
    aborted = 1'b1;
  endtask

  // Runs one host command and samples the response on the falling edge
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdat,
                            output logic err);
    int   cycles;
    logic rsp_seen;
    rdat   = '0;
    err    = 1'b0;
    cycles = 0;
    @(negedge i_sys_clk);
    while (!o_cmd_ready) begin
      if (cycles == CMD_TIMEOUT) begin
        note_timeout("the command port to become ready");
        return;
      end
      cycles++;
      @(negedge i_sys_clk);
    end
    @(posedge i_sys_clk);
    i_cmd_valid <= 1'b1;
    i_cmd_we    <= we;
    i_cmd_adr   <= adr;
    i_cmd_dat   <= dat;
    i_cmd_sel   <= sel;
    @(posedge i_sys_clk);  // Accepted on this edge
    i_cmd_valid <= 1'b0;
    cycles   = 0;
    rsp_seen = 1'b0;
    while (!rsp_seen) begin
      if (cycles == CMD_TIMEOUT) begin
        note_timeout("a response");
        return;
      end
      @(posedge i_sys_clk);
      cycles++;
      @(negedge i_sys_clk);
      rsp_seen = o_rsp_valid;
    end
    rdat = o_rsp_dat;
    err  = o_rsp_err;
    if (cycles != RSP_LAT) begin
      $display("error o_rsp_valid latency expected %0h got %0h", RSP_LAT, cycles);
      err_cnt++;
    end
  endtask

  task automatic poll_until(input logic [31:0] adr, input logic [31:0] exp_dat);
    logic [31:0] rdat;
    logic        err;
    int          polls;
    polls = 0;
    rdat  = ~exp_dat;
    while (rdat !== exp_dat) begin
      if (polls == POLL_MAX) begin
        note_timeout("the timer to expire");
        return;
      end
      bus_access(1'b0, adr, '0, 4'hf, rdat, err);
      if (aborted) return;
      if (err !== 1'b0) begin
        $display("error o_rsp_err expected 0 got %h", err);
        err_cnt++;
        return;
      end
      polls++;
    end
  endtask

  // Nonzero magnitude waits for a sign change, zero waits for silence
  task automatic watch_sound(input logic [15:0] mag);
    logic [15:0] snd;
    logic [15:0] first;
    int          cycles;
    logic        done;
    cycles = 0;
    done   = 1'b0;
    @(negedge i_sys_clk);
    first = o_sound;
    while (!done) begin
      snd = o_sound;
      if (mag == 16'h0) begin
        done = (snd === 16'h0);
      end else begin
        if (snd !== mag && snd !== -mag) begin
          $display("error o_sound expected %h or %h got %h", mag, -mag, snd);
          err_cnt++;
          return;
        end
        done = (snd !== first);
      end
      if (!done) begin
        if (cycles == SND_TIMEOUT) begin
          note_timeout("o_sound to change");
          return;
        end
        cycles++;
        @(negedge i_sys_clk);
      end
    end
  endtask

  task automatic run_step(input logic [7:0] op, input logic [31:0] adr,
                          input logic [31:0] dat, input logic [3:0] sel,
                          input logic [31:0] exp_dat, input logic exp_err);
    logic [31:0] rdat;
    logic        err;
    logic [7:0]  pins;
    case (op)
      "W", "R": begin
        bus_access(op == "W", adr, dat, sel, rdat, err);
        if (!aborted && err !== exp_err) begin
          $display("error o_rsp_err expected %h got %h", exp_err, err);
          err_cnt++;
        end
        if (!aborted && op == "R" && rdat !== exp_dat) begin
          $display("error o_rsp_dat expected %h got %h", exp_dat, rdat);
          err_cnt++;
        end
      end
      "T": poll_until(adr, exp_dat);
      "S": watch_sound(exp_dat[15:0]);
      "O": begin
        @(negedge i_sys_clk);
        if (o_gpio !== exp_dat[GPIO_W-1:0]) begin
          $display("error o_gpio expected %h got %h", exp_dat[GPIO_W-1:0], o_gpio);
          err_cnt++;
        end
      end
      "G": begin
        pins = take_bits(GPIO_W);
        @(posedge i_sys_clk);
        i_gpio <= pins;
        repeat (GPIO_SETTLE) @(posedge i_sys_clk);  // Two sync flops plus margin
        bus_access(1'b0, adr, '0, sel, rdat, err);
        if (!aborted && err !== 1'b0) begin
          $display("error o_rsp_err expected 0 got %h", err);
          err_cnt++;
        end
        if (!aborted && rdat !== {24'h0, pins}) begin
          $display("error o_rsp_dat expected %h got %h", {24'h0, pins}, rdat);
          err_cnt++;
        end
      end
      default: begin
        $display("unknown operation %c in the golden file", op);
        err_cnt++;
      end
    endcase
  endtask

  initial begin
    int          fd;
    int          n;
    int          err_before;
    string       line;
    logic [7:0]  op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp_dat;
    logic [3:0]  sel;
    logic        exp_err;
    i_rst_n     = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd_we    = 1'b0;
    i_cmd_adr   = '0;
    i_cmd_dat   = '0;
    i_cmd_sel   = '0;
    i_gpio      = '0;
    lfsr_q      = 32'h87c1_2636;
    err_cnt     = 0;
    step_cnt    = 0;
    aborted     = 1'b0;
    repeat (2) @(posedge i_sys_clk);
    @(negedge i_sys_clk);
    if (o_cmd_ready !== 1'b0 || o_rsp_valid !== 1'b0) begin
      $display("error o_cmd_ready o_rsp_valid expected 0 got %h", {o_cmd_ready, o_rsp_valid});
      err_cnt++;
    end
    if (o_gpio !== '0 || o_sound !== '0) begin
      $display("error o_gpio o_sound expected 0 got %h %h", o_gpio, o_sound);
      err_cnt++;
    end
    @(posedge i_sys_clk);
    i_rst_n <= 1'b1;  // Third edge ends reset
    fd = $fopen("tests/psg_test_soc_golden.txt", "r");
    if (fd == 0) begin
      $display("the golden file could not be opened");
      err_cnt++;
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        n = $sscanf(line, "%c %h %h %h %h %h", op, adr, dat, sel, exp_dat, exp_err);
        if (n == 6 && op != "#") begin
          step_cnt++;
          err_before = err_cnt;
          repeat (take_bits(2)) @(posedge i_sys_clk);  // 0 to 3 idle cycles
          run_step(op, adr, dat, sel, exp_dat, exp_err);
          $display("step %0d %c %h %s", step_cnt, op, adr,
                   (err_cnt == err_before) ? "ok" : "FAIL");
        end
      end
      $fclose(fd);
    end
    $display("steps run %0d, errors %0d", step_cnt, err_cnt);
    if (err_cnt == 0 && step_cnt > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* hw/psg_test_soc.sv */
`timescale 1ns/100ps

module psg_test_soc
  import soc_pkg::*;
(
  input  logic                        i_sys_clk,
  input  logic                        i_rst_n,
  input  logic                        i_cmd_valid,
  input  logic                        i_cmd_we,
  input  logic [WB_AW-1:0]            i_cmd_adr,
  input  logic [WB_DW-1:0]            i_cmd_dat,
  input  logic [WB_SW-1:0]            i_cmd_sel,
  output logic                        o_cmd_ready,
  output logic                        o_rsp_valid,
  output logic [WB_DW-1:0]            o_rsp_dat,
  output logic                        o_rsp_err,
  input  logic [GPIO_W-1:0]           i_gpio,
  output logic [GPIO_W-1:0]           o_gpio,
  output logic signed [PSG_SND_W-1:0] o_sound
);

  // Master side
  logic             m_cyc, m_stb, m_we, m_ack, m_err, m_stall;
  logic [WB_AW-1:0] m_adr;
  logic [WB_DW-1:0] m_dat_w, m_dat_r;
  logic [WB_SW-1:0] m_sel;

  // Slave side, indexed by wb_slave_e
  logic [NR_SLAVE-1:0] s_cyc, s_stb, s_ack;
  logic [WB_DW-1:0]    s_dat_r [NR_SLAVE];
  logic                s_we;
  logic [WB_AW-1:0]    s_adr;
  logic [WB_DW-1:0]    s_dat_w;
  logic [WB_SW-1:0]    s_sel;

  wb_host_bridge u_bridge (
    .i_sys_clk, .i_rst_n,
    .i_cmd_valid, .i_cmd_we, .i_cmd_adr, .i_cmd_dat, .i_cmd_sel,
    .o_cmd_ready, .o_rsp_valid, .o_rsp_dat, .o_rsp_err,
    .i_wb_dat_r (m_dat_r), .i_wb_ack (m_ack), .i_wb_err (m_err), .i_wb_stall (m_stall),
    .o_wb_cyc (m_cyc), .o_wb_stb (m_stb), .o_wb_we (m_we),
    .o_wb_adr (m_adr), .o_wb_dat_w (m_dat_w), .o_wb_sel (m_sel)
  );

  wb_interconnect_sharedbus u_intercon (
    .i_sys_clk, .i_rst_n,
    .i_m_cyc (m_cyc), .i_m_stb (m_stb), .i_m_we (m_we),
    .i_m_adr (m_adr), .i_m_dat_w (m_dat_w), .i_m_sel (m_sel),
    .o_m_dat_r (m_dat_r), .o_m_ack (m_ack), .o_m_err (m_err), .o_m_stall (m_stall),
    .i_s_ack (s_ack), .i_s_dat_r (s_dat_r),
    .o_s_cyc (s_cyc), .o_s_stb (s_stb), .o_s_we (s_we),
    .o_s_adr (s_adr), .o_s_dat_w (s_dat_w), .o_s_sel (s_sel)
  );

  wb_spram u_spram (
    .i_sys_clk, .i_rst_n,
    .i_wb_cyc (s_cyc[RAM_S]), .i_wb_stb (s_stb[RAM_S]), .i_wb_we (s_we),
    .i_wb_adr (s_adr), .i_wb_dat_w (s_dat_w), .i_wb_sel (s_sel),
    .o_wb_ack (s_ack[RAM_S]), .o_wb_dat_r (s_dat_r[RAM_S])
  );

  wb_gpio u_gpio (
    .i_sys_clk, .i_rst_n,
    .i_wb_cyc (s_cyc[GPIO_S]), .i_wb_stb (s_stb[GPIO_S]), .i_wb_we (s_we),
    .i_wb_adr (s_adr), .i_wb_dat_w (s_dat_w), .i_wb_sel (s_sel),
    .o_wb_ack (s_ack[GPIO_S]), .o_wb_dat_r (s_dat_r[GPIO_S]),
    .i_gpio, .o_gpio
  );

  wb_timer u_timer (
    .i_sys_clk, .i_rst_n,
    .i_wb_cyc (s_cyc[TIMER_S]), .i_wb_stb (s_stb[TIMER_S]), .i_wb_we (s_we),
    .i_wb_adr (s_adr), .i_wb_dat_w (s_dat_w), .i_wb_sel (s_sel),
    .o_wb_ack (s_ack[TIMER_S]), .o_wb_dat_r (s_dat_r[TIMER_S])
  );

  psg_wb u_psg (
    .i_sys_clk, .i_rst_n,
    .i_wb_cyc (s_cyc[PSG_S]), .i_wb_stb (s_stb[PSG_S]), .i_wb_we (s_we),
    .i_wb_adr (s_adr), .i_wb_dat_w (s_dat_w), .i_wb_sel (s_sel),
    .o_wb_ack (s_ack[PSG_S]), .o_wb_dat_r (s_dat_r[PSG_S]),
    .o_sound
  );

endmodule

/* psg/psg_wb.sv */
`timescale 1ns/100ps

module psg_wb
  import soc_pkg::*;
(
  input  logic                        i_sys_clk,
  input  logic                        i_rst_n,
  input  logic                        i_wb_cyc,
  input  logic                        i_wb_stb,
  input  logic                        i_wb_we,
  input  logic [WB_AW-1:0]            i_wb_adr,
  input  logic [WB_DW-1:0]            i_wb_dat_w,
  input  logic [WB_SW-1:0]            i_wb_sel,
  output logic                        o_wb_ack,
  output logic [WB_DW-1:0]            o_wb_dat_r,
  output logic signed [PSG_SND_W-1:0] o_sound
);

  logic [PSG_PERIOD_W-1:0]     period_q [PSG_NCH];
  logic [PSG_VOL_W-1:0]        volume_q [PSG_NCH];
  logic [PSG_NCH-1:0]          enable_q;
  logic [PSG_DIV_W-1:0]        div_q;
  logic                        tick;
  logic signed [PSG_SND_W-1:0] amp [PSG_NCH];
  logic signed [PSG_SND_W-1:0] mix;
  logic [WB_DW-1:0]            rd_word;
  logic [1:0]                  reg_idx;
  logic                        acc;

  assign acc     = i_wb_cyc & i_wb_stb;
  assign reg_idx = i_wb_adr[3:2];
  assign tick    = (div_q == PSG_DIV_W'(PSG_DIV - 1));

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_ack <= 1'b0;
      enable_q <= '0;
      div_q    <= '0;
      o_sound  <= '0;
      for (int k = 0; k < PSG_NCH; k++) begin
        period_q[k] <= '0;
        volume_q[k] <= '0;
      end
    end else begin
      o_wb_ack <= acc;
      div_q    <= tick ? '0 : div_q + 1'b1;
      o_sound  <= mix;
      if (acc && i_wb_we) begin
        if (reg_idx == 2'(PSG_NCH)) begin
          if (i_wb_sel[0]) enable_q <= i_wb_dat_w[PSG_NCH-1:0];  // Enable mask
        end else begin
          if (i_wb_sel[0]) period_q[reg_idx][7:0] <= i_wb_dat_w[7:0];
          if (i_wb_sel[1]) begin
            period_q[reg_idx][PSG_PERIOD_W-1:8] <= i_wb_dat_w[PSG_PERIOD_W-1:8];
          end
          if (i_wb_sel[2]) volume_q[reg_idx] <= i_wb_dat_w[16 +: PSG_VOL_W];
        end
      end
    end
  end

  always_comb begin
    rd_word = '0;
    if (reg_idx == 2'(PSG_NCH)) begin
      rd_word[PSG_NCH-1:0] = enable_q;
    end else begin
      rd_word[PSG_PERIOD_W-1:0] = period_q[reg_idx];
      rd_word[16 +: PSG_VOL_W]  = volume_q[reg_idx];
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (acc) o_wb_dat_r <= rd_word;
  end

  for (genvar k = 0; k < PSG_NCH; k++) begin : g_ch
    psg_channel u_channel (
      .i_sys_clk (i_sys_clk),
      .i_rst_n   (i_rst_n),
      .i_tick    (tick),
      .i_period  (period_q[k]),
      .i_volume  (volume_q[k]),
      .i_enable  (enable_q[k]),
      .o_amp     (amp[k])
    );
  end

  // Three full-scale channels still fit in 16 bits
  always_comb begin
    mix = '0;
    for (int k = 0; k < PSG_NCH; k++) begin
      mix = mix + amp[k];
    end
  end

endmodule

/* psg/psg_channel.sv */
`timescale 1ns/100ps

module psg_channel
  import soc_pkg::*;
(
  input  logic                        i_sys_clk,
  input  logic                        i_rst_n,
  input  logic                        i_tick,
  input  logic [PSG_PERIOD_W-1:0]     i_period,
  input  logic [PSG_VOL_W-1:0]        i_volume,
  input  logic                        i_enable,
  output logic signed [PSG_SND_W-1:0] o_amp
);

  logic [PSG_PERIOD_W-1:0]     cnt_q;
  logic                        phase_q;
  logic signed [PSG_SND_W-1:0] mag;

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_q   <= '0;
      phase_q <= 1'b0;
    end else if (!i_enable) begin
      cnt_q   <= '0;  // Restart cleanly on enable
      phase_q <= 1'b0;
    end else if (i_tick && i_period != '0) begin
      if (cnt_q >= i_period - 1'b1) begin
        cnt_q   <= '0;
        phase_q <= ~phase_q;  // Half period done
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign mag = PSG_SND_W'(i_volume) * PSG_SND_W'(PSG_VOL_STEP);

  always_comb begin
    if (!i_enable) begin
      o_amp = '0;
    end else begin
      o_amp = phase_q ? -mag : mag;
    end
  end

endmodule

/* hw/wb_timer.sv */
`timescale 1ns/100ps

module wb_timer
  import soc_pkg::*;
(
  input  logic             i_sys_clk,
  input  logic             i_rst_n,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [WB_AW-1:0] i_wb_adr,
  input  logic [WB_DW-1:0] i_wb_dat_w,
  input  logic [WB_SW-1:0] i_wb_sel,
  output logic             o_wb_ack,
  output logic [WB_DW-1:0] o_wb_dat_r
);

  logic [WB_DW-1:0] count_q;
  logic [WB_DW-1:0] load_val;
  logic             expired_q;
  logic             acc;
  logic             load;

  assign acc  = i_wb_cyc & i_wb_stb;
  assign load = acc & i_wb_we & ~i_wb_adr[2];

  // Unselected bytes keep the running count
  always_comb begin
    load_val = count_q;
    for (int b = 0; b < WB_SW; b++) begin
      if (i_wb_sel[b]) load_val[8*b +: 8] = i_wb_dat_w[8*b +: 8];
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_ack  <= 1'b0;
      count_q   <= '0;
      expired_q <= 1'b0;
    end else begin
      o_wb_ack <= acc;
      if (load) begin
        count_q   <= load_val;
        expired_q <= (load_val == '0);
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
        if (count_q == 1) expired_q <= 1'b1;  // Reaching zero
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (acc) begin
      o_wb_dat_r <= i_wb_adr[2] ? {{(WB_DW-1){1'b0}}, expired_q} : count_q;
    end
  end

endmodule

/* hw/wb_gpio.sv */
`timescale 1ns/100ps

module wb_gpio
  import soc_pkg::*;
(
  input  logic              i_sys_clk,
  input  logic              i_rst_n,
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  logic [WB_AW-1:0]  i_wb_adr,
  input  logic [WB_DW-1:0]  i_wb_dat_w,
  input  logic [WB_SW-1:0]  i_wb_sel,
  output logic              o_wb_ack,
  output logic [WB_DW-1:0]  o_wb_dat_r,
  input  logic [GPIO_W-1:0] i_gpio,
  output logic [GPIO_W-1:0] o_gpio
);

  logic [GPIO_W-1:0] gpio_meta;
  logic [GPIO_W-1:0] gpio_sync;
  logic              acc;
  logic              in_reg;

  assign acc    = i_wb_cyc & i_wb_stb;
  assign in_reg = i_wb_adr[2];  // Offset 4 is the input register

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_ack  <= 1'b0;
      o_gpio    <= '0;
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      o_wb_ack  <= acc;
      gpio_meta <= i_gpio;
      gpio_sync <= gpio_meta;
      // Whole low byte written, byte selects not decoded
      if (acc && i_wb_we && !in_reg) o_gpio <= i_wb_dat_w[GPIO_W-1:0];
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (acc) begin
      o_wb_dat_r <= {{(WB_DW-GPIO_W){1'b0}}, (in_reg ? gpio_sync : o_gpio)};
    end
  end

endmodule

/* hw/wb_spram.sv */
`timescale 1ns/100ps

module wb_spram
  import soc_pkg::*;
(
  input  logic             i_sys_clk,
  input  logic             i_rst_n,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [WB_AW-1:0] i_wb_adr,
  input  logic [WB_DW-1:0] i_wb_dat_w,
  input  logic [WB_SW-1:0] i_wb_sel,
  output logic             o_wb_ack,
  output logic [WB_DW-1:0] o_wb_dat_r
);

  logic [WB_DW-1:0]  mem [RAM_DEPTH];
  logic [RAM_AW-1:0] word_idx;
  logic              acc;

  assign acc      = i_wb_cyc & i_wb_stb;
  assign word_idx = i_wb_adr[RAM_AW+1:2];  // Word index from byte address

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= acc;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (acc) begin
      if (i_wb_we) begin
        for (int b = 0; b < WB_SW; b++) begin
          if (i_wb_sel[b]) mem[word_idx][8*b +: 8] <= i_wb_dat_w[8*b +: 8];
        end
      end
      o_wb_dat_r <= mem[word_idx];
    end
  end

endmodule

/* hw/wb_interconnect_sharedbus.sv */
`timescale 1ns/100ps

module wb_interconnect_sharedbus
  import soc_pkg::*;
(
  input  logic                i_sys_clk,
  input  logic                i_rst_n,
  // Master side
  input  logic                i_m_cyc,
  input  logic                i_m_stb,
  input  logic                i_m_we,
  input  logic [WB_AW-1:0]    i_m_adr,
  input  logic [WB_DW-1:0]    i_m_dat_w,
  input  logic [WB_SW-1:0]    i_m_sel,
  output logic [WB_DW-1:0]    o_m_dat_r,
  output logic                o_m_ack,
  output logic                o_m_err,
  output logic                o_m_stall,
  // Slave side
  input  logic [NR_SLAVE-1:0] i_s_ack,
  input  logic [WB_DW-1:0]    i_s_dat_r [NR_SLAVE],
  output logic [NR_SLAVE-1:0] o_s_cyc,
  output logic [NR_SLAVE-1:0] o_s_stb,
  output logic                o_s_we,
  output logic [WB_AW-1:0]    o_s_adr,
  output logic [WB_DW-1:0]    o_s_dat_w,
  output logic [WB_SW-1:0]    o_s_sel
);

  logic [NR_SLAVE-1:0] slv_sel;
  logic [NR_SLAVE-1:0] slv_sel_q;  // Held for the data phase
  logic                req_acc;
  logic                err_q;

  function automatic logic in_range(input logic [WB_AW-1:0] adr,
                                    input logic [WB_AW-1:0] base,
                                    input logic [WB_AW-1:0] size);
    in_range = (adr >= base) && ((adr - base) < size);
  endfunction

  // Address decode
  assign slv_sel[RAM_S]   = in_range(i_m_adr, RAM_BASE, RAM_SIZE);
  assign slv_sel[GPIO_S]  = in_range(i_m_adr, GPIO_BASE, GPIO_SIZE);
  assign slv_sel[TIMER_S] = in_range(i_m_adr, TIMER_BASE, TIMER_SIZE);
  assign slv_sel[PSG_S]   = in_range(i_m_adr, PSG_BASE, PSG_SIZE);

  // No slave ever stalls
  assign o_m_stall = 1'b0;
  assign req_acc   = i_m_cyc & i_m_stb & ~o_m_stall;

  assign o_s_cyc   = {NR_SLAVE{i_m_cyc}} & slv_sel;
  assign o_s_stb   = {NR_SLAVE{i_m_stb}} & slv_sel;
  assign o_s_we    = i_m_we;
  assign o_s_adr   = i_m_adr;
  assign o_s_dat_w = i_m_dat_w;
  assign o_s_sel   = i_m_sel;

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      slv_sel_q <= '0;
      err_q     <= 1'b0;
    end else begin
      err_q <= req_acc & ~|slv_sel;  // Unmapped address
      if (req_acc) begin
        slv_sel_q <= slv_sel;
      end else if (!i_m_cyc) begin
        slv_sel_q <= '0;
      end
    end
  end

  assign o_m_ack = |(i_s_ack & slv_sel_q);
  assign o_m_err = err_q;

  // Read data, zero when nothing selected
  always_comb begin
    o_m_dat_r = '0;
    for (int k = 0; k < NR_SLAVE; k++) begin
      if (slv_sel_q[k]) begin
        o_m_dat_r = o_m_dat_r | i_s_dat_r[k];
      end
    end
  end

endmodule

/* hw/wb_host_bridge.sv */
`timescale 1ns/100ps

module wb_host_bridge
  import soc_pkg::*;
(
  input  logic             i_sys_clk,
  input  logic             i_rst_n,
  // Host command port
  input  logic             i_cmd_valid,
  input  logic             i_cmd_we,
  input  logic [WB_AW-1:0] i_cmd_adr,
  input  logic [WB_DW-1:0] i_cmd_dat,
  input  logic [WB_SW-1:0] i_cmd_sel,
  output logic             o_cmd_ready,
  output logic             o_rsp_valid,
  output logic [WB_DW-1:0] o_rsp_dat,
  output logic             o_rsp_err,
  // Wishbone master
  input  logic [WB_DW-1:0] i_wb_dat_r,
  input  logic             i_wb_ack,
  input  logic             i_wb_err,
  input  logic             i_wb_stall,
  output logic             o_wb_cyc,
  output logic             o_wb_stb,
  output logic             o_wb_we,
  output logic [WB_AW-1:0] o_wb_adr,
  output logic [WB_DW-1:0] o_wb_dat_w,
  output logic [WB_SW-1:0] o_wb_sel
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    RESP
  } bridge_state_e;

  bridge_state_e state_q;
  logic          cmd_acc;
  logic          wb_done;

  assign cmd_acc = i_cmd_valid & o_cmd_ready;
  assign wb_done = o_wb_cyc & (i_wb_ack | i_wb_err);  // Only possible in WAIT

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q     <= IDLE;
      o_cmd_ready <= 1'b0;
      o_rsp_valid <= 1'b0;
      o_wb_cyc    <= 1'b0;
      o_wb_stb    <= 1'b0;
    end else begin
      o_rsp_valid <= 1'b0;
      case (state_q)
        IDLE: begin
          if (cmd_acc) begin
            o_cmd_ready <= 1'b0;
            state_q     <= REQ;
          end else begin
            o_cmd_ready <= 1'b1;  // Rises one cycle out of reset
          end
        end
        REQ: begin
          o_wb_cyc <= 1'b1;
          o_wb_stb <= 1'b1;
          state_q  <= WAIT;
        end
        WAIT: begin
          if (o_wb_stb && !i_wb_stall) begin
            o_wb_stb <= 1'b0;  // Request taken, hold cyc only
          end
          if (wb_done) begin
            o_wb_cyc    <= 1'b0;
            o_wb_stb    <= 1'b0;
            o_rsp_valid <= 1'b1;
            state_q     <= RESP;
          end
        end
        RESP: begin
          o_cmd_ready <= 1'b1;
          state_q     <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Command and response payload
  always_ff @(posedge i_sys_clk) begin
    if (cmd_acc) begin
      o_wb_we    <= i_cmd_we;
      o_wb_adr   <= i_cmd_adr;
      o_wb_dat_w <= i_cmd_dat;
      o_wb_sel   <= i_cmd_sel;
    end
    if (wb_done) begin
      o_rsp_dat <= i_wb_err ? '0 : i_wb_dat_r;
      o_rsp_err <= i_wb_err;
    end
  end

endmodule

/* common/soc_pkg.sv */
package soc_pkg;

  // Bus widths
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  localparam int WB_SW = WB_DW / 8;

  // Slave order sets the bit position in the select vectors
  typedef enum logic [1:0] {
    RAM_S,
    GPIO_S,
    TIMER_S,
    PSG_S
  } wb_slave_e;

  localparam int NR_SLAVE = 4;

  // Address map, byte addresses
  localparam logic [WB_AW-1:0] RAM_BASE   = 32'h0000_0000;
  localparam logic [WB_AW-1:0] RAM_SIZE   = 32'h0000_0400;
  localparam logic [WB_AW-1:0] GPIO_BASE  = 32'h1000_0000;
  localparam logic [WB_AW-1:0] GPIO_SIZE  = 32'h0000_0010;
  localparam logic [WB_AW-1:0] PSG_BASE   = 32'h1000_1000;
  localparam logic [WB_AW-1:0] PSG_SIZE   = 32'h0000_0400;
  localparam logic [WB_AW-1:0] TIMER_BASE = 32'h1002_0000;
  localparam logic [WB_AW-1:0] TIMER_SIZE = 32'h0000_0010;

  localparam int RAM_DEPTH = RAM_SIZE / WB_SW;  // 256 words
  localparam int RAM_AW    = $clog2(RAM_DEPTH);

  localparam int GPIO_W = 8;

  // Sound generator
  localparam int PSG_NCH      = 3;
  localparam int PSG_PERIOD_W = 12;
  localparam int PSG_VOL_W    = 4;
  localparam int PSG_DIV      = 4;            // sys_clk cycles per tick
  localparam int PSG_DIV_W    = $clog2(PSG_DIV);
  localparam int PSG_VOL_STEP = 512;          // Sound units per volume step
  localparam int PSG_SND_W    = 16;

endpackage
